// File: common/core_pkg.sv
// widths, data types, status flag positions and sequencer states of the core
// imported by every core module that needs them
package core_pkg;

	localparam int PC_WIDTH = 11;
	localparam int DATA_WIDTH = 8;
	localparam int REG_IDX_WIDTH = 5;
	localparam int REG_COUNT = 32;
	localparam int IO_ADDR_WIDTH = 6;

	// status register bit positions, bits 7:6 stay zero
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_V = 3;
	localparam int FLAG_S = 4;
	localparam int FLAG_H = 5;

	typedef logic [PC_WIDTH-1:0] pc_t;
	typedef logic [DATA_WIDTH-1:0] byte_t;
	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
	typedef logic [IO_ADDR_WIDTH-1:0] io_addr_t;
	typedef logic [DATA_WIDTH-1:0] flags_t;

	// NORMAL runs one word, STALL waits for a branch target,
	// WRITEBACK stores the IN data
	typedef enum logic [1:0] {
		NORMAL,
		STALL,
		WRITEBACK
	} seq_state_t;

endpackage

// File: common/isa_pkg.sv
// instruction word layout, ALU operations and instruction classes
// shared by the decoder, the ALU and the sequencer
package isa_pkg;

	typedef logic [15:0] instr_t;

	// operand field positions in the instruction word
	localparam int FLD_RD_LO = 4;
	localparam int FLD_RD_HI = 8;
	localparam int FLD_RR_HI = 9;
	localparam int FLD_K_HI_LSB = 8;
	localparam int FLD_IO_HI_LSB = 9;
	localparam int FLD_BR_CLR = 10;
	localparam int FLD_BR_OFS_LSB = 3;

	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_MOV,
		ALU_LDI,
		ALU_COM,
		ALU_NEG,
		ALU_INC,
		ALU_DEC,
		ALU_LSR,
		ALU_ROR,
		ALU_ASR,
		ALU_SWAP,
		ALU_IN,
		ALU_NONE
	} alu_op_t;

	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_IN,
		CLS_OUT,
		CLS_BRANCH,
		CLS_NOP
	} instr_class_t;

endpackage

// File: core/instr_decode.sv
// combinational decoder for the kept instruction subset
// unknown words come out as NOP
`timescale 1ns/1ps

module instr_decode (
	input  isa_pkg::instr_t       instr,
	output isa_pkg::alu_op_t      op,
	output isa_pkg::instr_class_t cls,
	output core_pkg::reg_idx_t    rd,
	output core_pkg::reg_idx_t    rr,
	output core_pkg::byte_t       imm,
	output logic                  use_imm,
	output logic                  store_result,
	output core_pkg::io_addr_t    io_a,
	output logic [2:0]            br_bit,
	output logic                  br_set,
	output logic [6:0]            br_ofs
);
	import isa_pkg::*;

	always_comb begin
		op = ALU_NONE;
		cls = CLS_ALU;
		use_imm = 1'b0;
		store_result = 1'b1;
		casez (instr)
			16'b0000_11??_????_????: op = ALU_ADD;
			16'b0001_11??_????_????: op = ALU_ADC;
			16'b0001_10??_????_????: op = ALU_SUB;
			16'b0000_10??_????_????: op = ALU_SBC;
			16'b0010_00??_????_????: op = ALU_AND;
			16'b0010_01??_????_????: op = ALU_EOR;
			16'b0010_10??_????_????: op = ALU_OR;
			16'b0010_11??_????_????: op = ALU_MOV;
			// compares run the subtract path but keep Rd
			16'b0001_01??_????_????: begin
				op = ALU_SUB;
				store_result = 1'b0;
			end
			16'b0000_01??_????_????: begin
				op = ALU_SBC;
				store_result = 1'b0;
			end
			16'b0011_????_????_????: begin
				op = ALU_SUB;
				use_imm = 1'b1;
				store_result = 1'b0;
			end
			16'b0100_????_????_????: {op, use_imm} = {ALU_SBC, 1'b1};
			16'b0101_????_????_????: {op, use_imm} = {ALU_SUB, 1'b1};
			16'b0110_????_????_????: {op, use_imm} = {ALU_OR, 1'b1};
			16'b0111_????_????_????: {op, use_imm} = {ALU_AND, 1'b1};
			16'b1110_????_????_????: {op, use_imm} = {ALU_LDI, 1'b1};
			16'b1001_010?_????_0000: op = ALU_COM;
			16'b1001_010?_????_0001: op = ALU_NEG;
			16'b1001_010?_????_0010: op = ALU_SWAP;
			16'b1001_010?_????_0011: op = ALU_INC;
			16'b1001_010?_????_0101: op = ALU_ASR;
			16'b1001_010?_????_0110: op = ALU_LSR;
			16'b1001_010?_????_0111: op = ALU_ROR;
			16'b1001_010?_????_1010: op = ALU_DEC;
			16'b1011_0???_????_????: {op, cls} = {ALU_IN, CLS_IN};
			16'b1011_1???_????_????: {cls, store_result} = {CLS_OUT, 1'b0};
			16'b1111_0???_????_????: {cls, store_result} = {CLS_BRANCH, 1'b0};
			default: {cls, store_result} = {CLS_NOP, 1'b0};
		endcase
	end

	// immediate forms only reach r16 to r31
	assign rd = {use_imm | instr[FLD_RD_HI], instr[FLD_RD_HI-1:FLD_RD_LO]};
	assign rr = {instr[FLD_RR_HI], instr[3:0]};
	assign imm = {instr[FLD_K_HI_LSB +: 4], instr[3:0]};
	assign io_a = {instr[FLD_IO_HI_LSB +: 2], instr[3:0]};
	assign br_bit = instr[2:0];
	assign br_set = ~instr[FLD_BR_CLR];
	assign br_ofs = instr[FLD_BR_OFS_LSB +: 7];

endmodule

// File: core/reg_file.sv
// 32 x 8-bit general purpose registers
// two combinational read ports, one write port on the clock edge
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               rst,
	input  core_pkg::reg_idx_t rd_idx,
	input  core_pkg::reg_idx_t rr_idx,
	output core_pkg::byte_t    rd_data,
	output core_pkg::byte_t    rr_data,
	input  logic               we,
	input  core_pkg::reg_idx_t wr_idx,
	input  core_pkg::byte_t    wr_data
);
	import core_pkg::*;

	byte_t regs [REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rd_data = regs[rd_idx];
	assign rr_data = regs[rr_idx];

	// a write with an unknown index would corrupt an arbitrary register
	assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown(wr_idx));

endmodule

// File: core/alu.sv
// 8-bit ALU with the status register
// flags and register writes take effect on the edge that ends exec_en
`timescale 1ns/1ps

module alu (
	input  logic              clk,
	input  logic              rst,
	input  isa_pkg::alu_op_t  op,
	input  core_pkg::byte_t   a,
	input  core_pkg::byte_t   b_reg,
	input  core_pkg::byte_t   imm,
	input  logic              use_imm,
	input  logic              store_result,
	input  logic              exec_en,
	input  core_pkg::byte_t   io_di,
	output core_pkg::byte_t   result,
	output logic              we,
	output core_pkg::flags_t  flags
);
	import core_pkg::*;
	import isa_pkg::*;

	byte_t      b;
	flags_t     nflags;
	logic [8:0] wide;
	logic       carry_in;
	logic       shift_in;
	logic       upd_nzs;

	assign b = use_imm ? imm : b_reg;
	assign carry_in = ((op == ALU_ADC) || (op == ALU_SBC)) && flags[FLAG_C];
	assign shift_in = (op == ALU_ROR) ? flags[FLAG_C] : ((op == ALU_ASR) ? a[7] : 1'b0);

	always_comb begin
		nflags = flags;
		result = a;
		upd_nzs = 1'b1;
		wide = '0;
		case (op)
			ALU_ADD, ALU_ADC: begin
				wide = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};
				result = wide[7:0];
				nflags[FLAG_C] = wide[8];
				nflags[FLAG_H] = (a[3] & b[3]) | (b[3] & ~result[3]) | (~result[3] & a[3]);
				nflags[FLAG_V] = (a[7] & b[7] & ~result[7]) | (~a[7] & ~b[7] & result[7]);
			end
			ALU_SUB, ALU_SBC: begin
				wide = {1'b0, a} - {1'b0, b} - {8'd0, carry_in};
				result = wide[7:0];
				nflags[FLAG_C] = wide[8];
				nflags[FLAG_H] = (~a[3] & b[3]) | (b[3] & result[3]) | (result[3] & ~a[3]);
				nflags[FLAG_V] = (a[7] & ~b[7] & ~result[7]) | (~a[7] & b[7] & result[7]);
			end
			ALU_AND: {result, nflags[FLAG_V]} = {a & b, 1'b0};
			ALU_OR: {result, nflags[FLAG_V]} = {a | b, 1'b0};
			ALU_EOR: {result, nflags[FLAG_V]} = {a ^ b, 1'b0};
			ALU_COM: begin
				result = ~a;
				nflags[FLAG_V] = 1'b0;
				nflags[FLAG_C] = 1'b1;
			end
			ALU_NEG: begin
				wide = 9'd0 - {1'b0, a};
				result = wide[7:0];
				// carry set for any nonzero operand
				nflags[FLAG_C] = wide[8];
				nflags[FLAG_H] = result[3] | a[3];
				nflags[FLAG_V] = (result == 8'h80);
			end
			ALU_INC: {result, nflags[FLAG_V]} = {a + 8'd1, a == 8'h7f};
			ALU_DEC: {result, nflags[FLAG_V]} = {a - 8'd1, a == 8'h80};
			ALU_LSR, ALU_ROR, ALU_ASR: begin
				result = {shift_in, a[7:1]};
				nflags[FLAG_C] = a[0];
				nflags[FLAG_V] = shift_in ^ a[0];
			end
			ALU_SWAP: {result, upd_nzs} = {a[3:0], a[7:4], 1'b0};
			ALU_MOV, ALU_LDI: {result, upd_nzs} = {b, 1'b0};
			ALU_IN: {result, upd_nzs} = {io_di, 1'b0};
			default: upd_nzs = 1'b0;
		endcase
		if (upd_nzs) begin
			nflags[FLAG_N] = result[7];
			// SBC, SBCI and CPC only keep Z when the chain so far was zero
			nflags[FLAG_Z] = (result == 8'h00) && ((op != ALU_SBC) || flags[FLAG_Z]);
			nflags[FLAG_S] = result[7] ^ nflags[FLAG_V];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else if (exec_en) begin
			flags <= nflags;
		end
	end

	assign we = exec_en & store_result;

	assert property (@(posedge clk) disable iff (rst) !$isunknown(flags));

endmodule

// File: core/sequencer.sv
// program counter, fetch control, branches and I/O strobes
// one instruction at a time, IN and taken branches use a second cycle
`timescale 1ns/1ps

module sequencer (
	input  logic                  clk,
	input  logic                  rst,
	input  isa_pkg::instr_class_t cls,
	input  core_pkg::flags_t      flags,
	input  logic [2:0]            br_bit,
	input  logic                  br_set,
	input  logic [6:0]            br_ofs,
	output logic                  pmem_ce,
	output core_pkg::pc_t         pmem_a,
	output logic                  exec_en,
	output logic                  io_re,
	output logic                  io_we
);
	import core_pkg::*;
	import isa_pkg::*;

	seq_state_t state;
	seq_state_t next_state;
	pc_t        pc;
	pc_t        pc_next;
	logic       fetch;
	logic       flag_sel;

	// T and the unused bit read as zero
	assign flag_sel = (int'(br_bit) <= FLAG_H) ? flags[br_bit] : 1'b0;

	always_comb begin
		next_state = state;
		pc_next = pc + pc_t'(1);
		fetch = 1'b1;
		exec_en = 1'b0;
		io_re = 1'b0;
		io_we = 1'b0;
		case (state)
			NORMAL: begin
				case (cls)
					CLS_ALU: exec_en = 1'b1;
					CLS_OUT: io_we = 1'b1;
					CLS_IN: begin
						// hold the word so the writeback still sees Rd
						io_re = 1'b1;
						fetch = 1'b0;
						pc_next = pc;
						next_state = WRITEBACK;
					end
					CLS_BRANCH: begin
						if (flag_sel == br_set) begin
							pc_next = pc + pc_t'({{(PC_WIDTH-7){br_ofs[6]}}, br_ofs});
							next_state = STALL;
						end
					end
					default: ;
				endcase
			end
			WRITEBACK: begin
				exec_en = 1'b1;
				next_state = NORMAL;
			end
			default: next_state = NORMAL;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= NORMAL;
			pc <= '0;
		end else begin
			state <= next_state;
			pc <= pc_next;
		end
	end

	// word 0 is fetched while reset is held
	assign pmem_ce = fetch | rst;
	assign pmem_a = rst ? '0 : pc + pc_t'(1);

	assert property (@(posedge clk) disable iff (rst) !(io_re && io_we));

endmodule

// File: core/navre_core.sv
// reduced AVR-style core, top level
// fetches from an external program memory and talks to one I/O port
`timescale 1ns/1ps

module navre_core (
	input  logic               clk,
	input  logic               rst,
	output logic               pmem_ce,
	output core_pkg::pc_t      pmem_a,
	input  isa_pkg::instr_t    pmem_d,
	output logic               io_re,
	output logic               io_we,
	output core_pkg::io_addr_t io_a,
	output core_pkg::byte_t    io_do,
	input  core_pkg::byte_t    io_di
);
	import core_pkg::*;
	import isa_pkg::*;

	alu_op_t      op;
	instr_class_t cls;
	reg_idx_t     rd;
	reg_idx_t     rr;
	byte_t        imm;
	logic         use_imm;
	logic         store_result;
	logic [2:0]   br_bit;
	logic         br_set;
	logic [6:0]   br_ofs;
	byte_t        rd_data;
	byte_t        rr_data;
	byte_t        alu_result;
	logic         alu_we;
	flags_t       flags;
	logic         exec_en;

	instr_decode instr_decode_i (
		.instr(pmem_d), .op(op), .cls(cls), .rd(rd), .rr(rr), .imm(imm),
		.use_imm(use_imm), .store_result(store_result), .io_a(io_a),
		.br_bit(br_bit), .br_set(br_set), .br_ofs(br_ofs)
	);

	// the destination index doubles as the write index
	reg_file reg_file_i (
		.clk(clk), .rst(rst), .rd_idx(rd), .rr_idx(rr),
		.rd_data(rd_data), .rr_data(rr_data),
		.we(alu_we), .wr_idx(rd), .wr_data(alu_result)
	);

	alu alu_i (
		.clk(clk), .rst(rst), .op(op), .a(rd_data), .b_reg(rr_data), .imm(imm),
		.use_imm(use_imm), .store_result(store_result), .exec_en(exec_en),
		.io_di(io_di), .result(alu_result), .we(alu_we), .flags(flags)
	);

	sequencer sequencer_i (
		.clk(clk), .rst(rst), .cls(cls), .flags(flags),
		.br_bit(br_bit), .br_set(br_set), .br_ofs(br_ofs),
		.pmem_ce(pmem_ce), .pmem_a(pmem_a),
		.exec_en(exec_en), .io_re(io_re), .io_we(io_we)
	);

	// OUT sends the register named in the Rd field
	assign io_do = rd_data;

endmodule

// File: sim/tb_navre.sv
// testbench for the reduced AVR-style core
// runs a random program from a fixed seed and checks every OUT against a reference model
`timescale 1ns/1ps

module tb_navre;
	import core_pkg::*;
	import isa_pkg::*;

	localparam int PROG_RANDOM = 300;
	localparam int PROG_LEN = PROG_RANDOM + REG_COUNT;
	localparam int TIMEOUT = 2000;
	localparam int MEM_WORDS = 2 ** PC_WIDTH;

	logic               clk;
	logic               rst;
	logic               pmem_ce;
	pc_t                pmem_a;
	instr_t             pmem_d;
	logic               io_re;
	logic               io_we;
	io_addr_t           io_a;
	byte_t              io_do;
	byte_t              io_di;

	instr_t             mem [MEM_WORDS];
	byte_t              io_table [64];
	int                 kind [PROG_LEN];
	int                 fd [PROG_LEN];
	int                 fr [PROG_LEN];
	int                 fk [PROG_LEN];
	byte_t              mreg [REG_COUNT];
	logic               fc, fz, fn, fv, fs, fh;
	logic [15:0]        lfsr;
	int                 exp_addr [$];
	byte_t              exp_val [$];

	navre_core navre_core_i (
		.clk(clk), .rst(rst), .pmem_ce(pmem_ce), .pmem_a(pmem_a), .pmem_d(pmem_d),
		.io_re(io_re), .io_we(io_we), .io_a(io_a), .io_do(io_do), .io_di(io_di)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// program memory loads on an enabled edge and holds otherwise
	always @(posedge clk) begin
		logic ce_q;
		pc_t  a_q;
		ce_q = pmem_ce;
		a_q = pmem_a;
		#1;
		if (ce_q) begin
			pmem_d = mem[a_q];
		end
	end

	// I/O device answers a read in the following cycle
	always @(posedge clk) begin
		logic     re_q;
		io_addr_t a_q;
		re_q = io_re;
		a_q = io_a;
		#1;
		if (re_q) begin
			io_di = io_table[a_q];
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	always @(negedge clk) begin
		if (rst) begin
			check("io_re", 32'(io_re), 0);
			check("io_we", 32'(io_we), 0);
		end else begin
			check("io_re & io_we", 32'(io_re & io_we), 0);
		end
	end

	// galois LFSR stepped once per bit taken
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return v;
	endfunction

	// kind 0-9 register ops, 10-15 immediate ops, 16-23 one-operand ops,
	// 24 IN, 25 OUT, 26 BRBS, 27 BRBC, 28 NOP
	function automatic instr_t encode(input int kd, input int d, input int r, input int k);
		logic [4:0] d5;
		logic [4:0] r5;
		logic [7:0] k8;
		d5 = d[4:0];
		r5 = r[4:0];
		k8 = k[7:0];
		case (kd)
			0: return {6'b000011, r5[4], d5, r5[3:0]};
			1: return {6'b000111, r5[4], d5, r5[3:0]};
			2: return {6'b000110, r5[4], d5, r5[3:0]};
			3: return {6'b000010, r5[4], d5, r5[3:0]};
			4: return {6'b001000, r5[4], d5, r5[3:0]};
			5: return {6'b001001, r5[4], d5, r5[3:0]};
			6: return {6'b001010, r5[4], d5, r5[3:0]};
			7: return {6'b001011, r5[4], d5, r5[3:0]};
			8: return {6'b000101, r5[4], d5, r5[3:0]};
			9: return {6'b000001, r5[4], d5, r5[3:0]};
			10: return {4'b0011, k8[7:4], d5[3:0], k8[3:0]};
			11: return {4'b0100, k8[7:4], d5[3:0], k8[3:0]};
			12: return {4'b0101, k8[7:4], d5[3:0], k8[3:0]};
			13: return {4'b0110, k8[7:4], d5[3:0], k8[3:0]};
			14: return {4'b0111, k8[7:4], d5[3:0], k8[3:0]};
			15: return {4'b1110, k8[7:4], d5[3:0], k8[3:0]};
			16: return {7'b1001010, d5, 4'h0};
			17: return {7'b1001010, d5, 4'h1};
			18: return {7'b1001010, d5, 4'h2};
			19: return {7'b1001010, d5, 4'h3};
			20: return {7'b1001010, d5, 4'h5};
			21: return {7'b1001010, d5, 4'h6};
			22: return {7'b1001010, d5, 4'h7};
			23: return {7'b1001010, d5, 4'ha};
			24: return {5'b10110, k8[5:4], d5, k8[3:0]};
			25: return {5'b10111, k8[5:4], d5, k8[3:0]};
			26: return {6'b111100, k8[6:0], r5[2:0]};
			27: return {6'b111101, k8[6:0], r5[2:0]};
			default: return 16'h0000;
		endcase
	endfunction

	task automatic build_program();
		int sel;
		for (int i = 0; i < 64; i++) begin
			io_table[i] = byte_t'(rand_bits(8));
		end
		for (int w = 0; w < MEM_WORDS; w++) begin
			mem[w] = 16'h0000;
		end
		for (int i = 0; i < PROG_RANDOM; i++) begin
			if (rand_bits(3) == 0) begin
				kind[i] = 25;
			end else begin
				sel = rand_bits(5) % 28;
				kind[i] = (sel >= 25) ? sel + 1 : sel;
			end
			fd[i] = rand_bits(5);
			fr[i] = rand_bits(5);
			fk[i] = rand_bits(8);
			if (kind[i] >= 10 && kind[i] <= 15) begin
				fd[i] = 16 + rand_bits(4);
			end else if (kind[i] == 24 || kind[i] == 25) begin
				fk[i] = rand_bits(6);
			end else if (kind[i] == 26 || kind[i] == 27) begin
				// forward only by 1 to 4 words
				fk[i] = 1 + rand_bits(2);
				fr[i] = rand_bits(3);
			end
			mem[i] = encode(kind[i], fd[i], fr[i], fk[i]);
		end
		// closing dump sends each register r_i to port i
		for (int j = 0; j < REG_COUNT; j++) begin
			kind[PROG_RANDOM + j] = 25;
			fd[PROG_RANDOM + j] = j;
			fr[PROG_RANDOM + j] = 0;
			fk[PROG_RANDOM + j] = j;
			mem[PROG_RANDOM + j] = encode(25, j, 0, j);
		end
	endtask

	function automatic void set_nzs(input byte_t r);
		fn = r[7];
		fz = (r == 8'h00);
		fs = r[7] ^ fv;
	endfunction

	function automatic byte_t add8(input byte_t a, input byte_t b, input logic cin);
		logic [8:0] w;
		logic [4:0] lo;
		w = {1'b0, a} + {1'b0, b} + 9'(cin);
		lo = {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(cin);
		fc = w[8];
		fh = lo[4];
		fv = (a[7] == b[7]) && (w[7] != a[7]);
		set_nzs(w[7:0]);
		return w[7:0];
	endfunction

	// keepz chains Z across a multi-byte subtract or compare
	function automatic byte_t sub8(input byte_t a, input byte_t b, input logic cin,
			input logic keepz);
		logic [8:0] w;
		logic [4:0] lo;
		logic       zold;
		w = {1'b0, a} - {1'b0, b} - 9'(cin);
		lo = {1'b0, a[3:0]} - {1'b0, b[3:0]} - 5'(cin);
		zold = fz;
		fc = w[8];
		fh = lo[4];
		fv = (a[7] != b[7]) && (w[7] != a[7]);
		set_nzs(w[7:0]);
		if (keepz) begin
			fz = fz & zold;
		end
		return w[7:0];
	endfunction

	function automatic byte_t shift_right(input byte_t a, input logic top);
		byte_t r;
		r = {top, a[7:1]};
		fc = a[0];
		fv = r[7] ^ fc;
		set_nzs(r);
		return r;
	endfunction

	function automatic logic flag_bit(input int s);
		case (s)
			0: return fc;
			1: return fz;
			2: return fn;
			3: return fv;
			4: return fs;
			5: return fh;
			default: return 1'b0;
		endcase
	endfunction

	task automatic run_model();
		int    pc;
		int    nxt;
		byte_t a;
		byte_t b;
		byte_t k;
		byte_t r;
		pc = 0;
		{fc, fz, fn, fv, fs, fh} = '0;
		for (int i = 0; i < REG_COUNT; i++) begin
			mreg[i] = 8'h00;
		end
		while (pc < PROG_LEN) begin
			a = mreg[fd[pc]];
			b = mreg[fr[pc]];
			k = fk[pc][7:0];
			nxt = pc + 1;
			case (kind[pc])
				0: mreg[fd[pc]] = add8(a, b, 1'b0);
				1: mreg[fd[pc]] = add8(a, b, fc);
				2: mreg[fd[pc]] = sub8(a, b, 1'b0, 1'b0);
				3: mreg[fd[pc]] = sub8(a, b, fc, 1'b1);
				4, 5, 6, 13, 14: begin
					if (kind[pc] >= 13) begin
						b = k;
					end
					r = (kind[pc] == 4 || kind[pc] == 14) ? (a & b) :
						((kind[pc] == 5) ? (a ^ b) : (a | b));
					fv = 1'b0;
					set_nzs(r);
					mreg[fd[pc]] = r;
				end
				7: mreg[fd[pc]] = b;
				8: r = sub8(a, b, 1'b0, 1'b0);
				9: r = sub8(a, b, fc, 1'b1);
				10: r = sub8(a, k, 1'b0, 1'b0);
				11: mreg[fd[pc]] = sub8(a, k, fc, 1'b1);
				12: mreg[fd[pc]] = sub8(a, k, 1'b0, 1'b0);
				15: mreg[fd[pc]] = k;
				16: begin
					r = ~a;
					fc = 1'b1;
					fv = 1'b0;
					set_nzs(r);
					mreg[fd[pc]] = r;
				end
				// NEG is zero minus Rd
				17: mreg[fd[pc]] = sub8(8'h00, a, 1'b0, 1'b0);
				18: mreg[fd[pc]] = {a[3:0], a[7:4]};
				19, 23: begin
					r = (kind[pc] == 19) ? a + 8'd1 : a - 8'd1;
					fv = (kind[pc] == 19) ? (r == 8'h80) : (r == 8'h7f);
					set_nzs(r);
					mreg[fd[pc]] = r;
				end
				20: mreg[fd[pc]] = shift_right(a, a[7]);
				21: mreg[fd[pc]] = shift_right(a, 1'b0);
				22: mreg[fd[pc]] = shift_right(a, fc);
				24: mreg[fd[pc]] = io_table[k[5:0]];
				25: begin
					exp_addr.push_back(fk[pc]);
					exp_val.push_back(a);
				end
				26, 27: begin
					if (flag_bit(fr[pc]) == (kind[pc] == 26)) begin
						nxt = pc + 1 + fk[pc];
					end
				end
				default: ;
			endcase
			pc = nxt;
		end
	endtask

	initial begin
		int waited;
		rst = 1'b1;
		pmem_d = 16'h0000;
		io_di = 8'h00;
		lfsr = 16'd26986;
		build_program();
		run_model();
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		@(negedge clk);
		check("pmem_d", 32'(pmem_d), 32'(mem[0]));
		for (int i = 0; i < exp_addr.size(); i++) begin
			waited = 0;
			while (!io_we) begin
				if (waited == TIMEOUT) begin
					$display("timeout: no io_we pulse for OUT event %0d within %0d cycles",
						i, TIMEOUT);
					$display("sim failed");
					$fatal(1);
				end
				waited++;
				@(negedge clk);
			end
			check("io_a", 32'(io_a), exp_addr[i]);
			check("io_do", 32'(io_do), 32'(exp_val[i]));
			@(negedge clk);
		end
		$display("sim passed");
		$finish;
	end

endmodule

// File: tb.f
common/core_pkg.sv
common/isa_pkg.sv
core/instr_decode.sv
core/reg_file.sv
core/alu.sv
core/sequencer.sv
core/navre_core.sv
sim/tb_navre.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module tb_navre -Mdir obj_dir

run: compile
	./obj_dir/Vtb_navre

clean:
	rm -rf obj_dir
